//--- include/amo_port_consts.svh
`ifndef AMO_PORT_CONSTS_SVH
`define AMO_PORT_CONSTS_SVH

// Scratchpad depth in 64-bit words
`define AMO_MEM_WORDS 256

// Byte address width, covers the whole scratchpad
`define AMO_ADDR_W 11

// Cycles an LR reservation stays valid after it is taken
`define AMO_LR_TIMEOUT 64

`endif

//--- src/core_if_pkg.sv
package core_if_pkg;

  // Atomic operations as issued by the core
  typedef enum logic [3:0] {
    AMO_LR   = 4'h0,
    AMO_SC   = 4'h1,
    AMO_SWAP = 4'h2,
    AMO_ADD  = 4'h3,
    AMO_AND  = 4'h4,
    AMO_OR   = 4'h5,
    AMO_XOR  = 4'h6,
    AMO_MAX  = 4'h7,
    AMO_MAXU = 4'h8,
    AMO_MIN  = 4'h9,
    AMO_MINU = 4'hA
  } amo_op_e;

  // Access size, log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } access_size_e;

endpackage

//--- src/mem_req_pkg.sv
package mem_req_pkg;

  // Operations on the memory request stream
  typedef enum logic [3:0] {
    MEM_LOAD     = 4'h0,
    MEM_STORE    = 4'h1,
    MEM_AMO_LR   = 4'h2,
    MEM_AMO_SC   = 4'h3,
    MEM_AMO_SWAP = 4'h4,
    MEM_AMO_ADD  = 4'h5,
    MEM_AMO_AND  = 4'h6,
    MEM_AMO_OR   = 4'h7,
    MEM_AMO_XOR  = 4'h8,
    MEM_AMO_MAX  = 4'h9,
    MEM_AMO_MAXU = 4'hA,
    MEM_AMO_MIN  = 4'hB,
    MEM_AMO_MINU = 4'hC
  } mem_op_e;

  // Request tag, echoed on the response
  typedef logic [3:0] mem_tid_t;

  // Tag reserved for atomic requests
  localparam mem_tid_t AMO_TID = 4'hF;

  // Scratchpad controller states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_READ   = 2'd1,
    ST_MODIFY = 2'd2,
    ST_RESP   = 2'd3
  } ctrl_state_e;

endpackage

//--- src/mem_req_if.sv
`timescale 1ns/1ps
`include "amo_port_consts.svh"

interface mem_req_if;
  import core_if_pkg::*;
  import mem_req_pkg::*;

  // Request channel
  logic                   req_valid;
  logic                   req_ready;
  mem_op_e                req_op;
  logic [`AMO_ADDR_W-1:0] req_addr;
  logic [63:0]            req_wdata;
  logic [7:0]             req_be;
  access_size_e           req_size;
  mem_tid_t               req_tid;
  logic                   req_need_rsp;

  // Response channel, single-cycle pulse
  logic                   rsp_valid;
  logic [63:0]            rsp_rdata;
  mem_tid_t               rsp_tid;

  modport requester (
    output req_valid, req_op, req_addr, req_wdata, req_be, req_size, req_tid, req_need_rsp,
    input  req_ready, rsp_valid, rsp_rdata, rsp_tid
  );

  modport responder (
    input  req_valid, req_op, req_addr, req_wdata, req_be, req_size, req_tid, req_need_rsp,
    output req_ready, rsp_valid, rsp_rdata, rsp_tid
  );

endinterface

//--- src/core_port_adapter.sv
`timescale 1ns/1ps
`include "amo_port_consts.svh"

module core_port_adapter (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Load/store channel
  input  logic                      data_req_i,
  input  logic                      data_we_i,
  input  logic [`AMO_ADDR_W-1:0]    data_addr_i,
  input  logic [63:0]               data_wdata_i,
  input  logic [7:0]                data_be_i,
  input  core_if_pkg::access_size_e data_size_i,
  input  mem_req_pkg::mem_tid_t     data_id_i,
  output logic                      data_gnt_o,
  output logic                      data_rvalid_o,
  output logic [63:0]               data_rdata_o,
  output mem_req_pkg::mem_tid_t     data_rid_o,
  // Atomic channel
  input  logic                      amo_req_i,
  input  core_if_pkg::amo_op_e      amo_op_i,
  input  logic [`AMO_ADDR_W-1:0]    amo_addr_i,
  input  logic [63:0]               amo_operand_i,
  input  core_if_pkg::access_size_e amo_size_i,
  output logic                      amo_ack_o,
  output logic [63:0]               amo_result_o,
  mem_req_if.requester              mem
);
  import core_if_pkg::*;
  import mem_req_pkg::*;

  logic        amo_sel;
  logic        amo_is_word;
  logic        amo_hi;
  mem_op_e     amo_mem_op;
  logic [63:0] amo_wdata;
  logic [7:0]  amo_be;
  logic        rsp_is_amo;
  logic [31:0] amo_rsp_word;
  logic        amo_pending_q;

  // Core opcode to memory opcode
  always_comb begin
    unique case (amo_op_i)
      AMO_LR:   amo_mem_op = MEM_AMO_LR;
      AMO_SC:   amo_mem_op = MEM_AMO_SC;
      AMO_SWAP: amo_mem_op = MEM_AMO_SWAP;
      AMO_ADD:  amo_mem_op = MEM_AMO_ADD;
      AMO_AND:  amo_mem_op = MEM_AMO_AND;
      AMO_OR:   amo_mem_op = MEM_AMO_OR;
      AMO_XOR:  amo_mem_op = MEM_AMO_XOR;
      AMO_MAX:  amo_mem_op = MEM_AMO_MAX;
      AMO_MAXU: amo_mem_op = MEM_AMO_MAXU;
      AMO_MIN:  amo_mem_op = MEM_AMO_MIN;
      AMO_MINU: amo_mem_op = MEM_AMO_MINU;
      default:  amo_mem_op = MEM_LOAD;
    endcase
  end

  // AMO channel owns the mux while its request is up, even when masked
  assign amo_sel     = amo_req_i;
  assign amo_is_word = (amo_size_i == SIZE_WORD);
  assign amo_hi      = amo_addr_i[2];

  // Word operand goes to both halves, byte enables pick the live one
  assign amo_wdata = amo_is_word ? {2{amo_operand_i[31:0]}} : amo_operand_i;
  assign amo_be    = !amo_is_word ? 8'hFF : (amo_hi ? 8'hF0 : 8'h0F);

  assign mem.req_valid    = data_req_i | (amo_req_i & ~amo_pending_q);
  assign mem.req_op       = amo_sel ? amo_mem_op : (data_we_i ? MEM_STORE : MEM_LOAD);
  assign mem.req_addr     = amo_sel ? amo_addr_i : data_addr_i;
  assign mem.req_wdata    = amo_sel ? amo_wdata : data_wdata_i;
  assign mem.req_be       = amo_sel ? amo_be : data_be_i;
  assign mem.req_size     = amo_sel ? amo_size_i : data_size_i;
  assign mem.req_tid      = amo_sel ? AMO_TID : data_id_i;
  // Stores are posted
  assign mem.req_need_rsp = amo_sel | ~data_we_i;

  assign data_gnt_o = mem.req_ready & ~amo_sel;

  // Response routing by tag
  assign rsp_is_amo    = (mem.rsp_tid == AMO_TID);
  assign data_rvalid_o = mem.rsp_valid & ~rsp_is_amo;
  assign data_rdata_o  = mem.rsp_rdata;
  assign data_rid_o    = mem.rsp_tid;
  assign amo_ack_o     = mem.rsp_valid & rsp_is_amo;

  // Address is still held by the core when the result comes back
  assign amo_rsp_word = amo_hi ? mem.rsp_rdata[63:32] : mem.rsp_rdata[31:0];

  always_comb begin
    if (amo_op_i == AMO_SC) begin
      // SC status sits in bit 0
      amo_result_o = {63'b0, mem.rsp_rdata[0]};
    end else if (amo_is_word) begin
      amo_result_o = {{32{amo_rsp_word[31]}}, amo_rsp_word};
    end else begin
      amo_result_o = mem.rsp_rdata;
    end
  end

  // One atomic in flight, from acceptance until its ack
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      amo_pending_q <= 1'b0;
    end else if (amo_ack_o) begin
      amo_pending_q <= 1'b0;
    end else if (amo_sel && mem.req_valid && mem.req_ready) begin
      amo_pending_q <= 1'b1;
    end
  end

  one_channel_a : assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({data_req_i, amo_req_i}))
    else $error("data and AMO requests raised together");

  // The mux relies on the core keeping the AMO up until its ack
  amo_held_a : assert property (@(posedge clk_i) disable iff (reset_i)
    amo_req_i && !amo_ack_o |=> amo_req_i)
    else $error("AMO request dropped before ack");

endmodule

//--- src/scratch_ctrl_fsm.sv
`timescale 1ns/1ps
`include "amo_port_consts.svh"

module scratch_ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   reset_i,
  mem_req_if.responder           mem,
  // Data unit side
  output logic                   rd_en_o,
  output logic                   wr_en_o,
  output logic [`AMO_ADDR_W-4:0] word_addr_o,
  output logic [63:0]            wdata_o,
  output logic [7:0]             be_o,
  output mem_req_pkg::mem_op_e   op_o,
  input  logic [63:0]            rdata_i,
  input  logic [63:0]            alu_result_i,
  // Reservation timer side
  output logic                   resv_set_o,
  output logic                   resv_clear_o,
  output logic [`AMO_ADDR_W-4:0] resv_addr_o,
  input  logic                   resv_valid_i,
  input  logic                   resv_hit_i
);
  import mem_req_pkg::*;

  ctrl_state_e            state_q;
  ctrl_state_e            state_d;
  mem_op_e                op_q;
  logic [`AMO_ADDR_W-4:0] addr_q;
  logic [63:0]            wdata_q;
  logic [7:0]             be_q;
  mem_tid_t               tid_q;
  logic                   need_rsp_q;
  logic                   sc_fail_q;
  logic                   accept;
  logic                   is_amo;
  logic                   sc_ok;

  assign accept = mem.req_valid & mem.req_ready;
  assign is_amo = (op_q != MEM_LOAD) && (op_q != MEM_STORE);
  assign sc_ok  = resv_valid_i & resv_hit_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        // Stores skip the read
        if (accept) begin
          state_d = (mem.req_op == MEM_STORE) ? ST_MODIFY : ST_READ;
        end
      end
      ST_READ: begin
        if (op_q == MEM_LOAD) begin
          state_d = need_rsp_q ? ST_RESP : ST_IDLE;
        end else begin
          state_d = ST_MODIFY;
        end
      end
      ST_MODIFY: state_d = need_rsp_q ? ST_RESP : ST_IDLE;
      ST_RESP:   state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q       <= mem.req_op;
      addr_q     <= mem.req_addr[`AMO_ADDR_W-1:3];
      wdata_q    <= mem.req_wdata;
      be_q       <= mem.req_be;
      tid_q      <= mem.req_tid;
      need_rsp_q <= mem.req_need_rsp;
    end
    // SC verdict taken before MODIFY drops the reservation
    if (state_q == ST_MODIFY) begin
      sc_fail_q <= ~sc_ok;
    end
  end

  assign mem.req_ready = (state_q == ST_IDLE);

  assign rd_en_o     = (state_q == ST_READ);
  assign wr_en_o     = (state_q == ST_MODIFY) &&
                       ((op_q == MEM_STORE) ||
                        (is_amo && (op_q != MEM_AMO_LR) && ((op_q != MEM_AMO_SC) || sc_ok)));
  assign word_addr_o = addr_q;
  // Raw operand during READ so the data unit can latch it
  assign wdata_o     = (state_q == ST_MODIFY && is_amo) ? alu_result_i : wdata_q;
  assign be_o        = be_q;
  assign op_o        = op_q;

  // Any write to the reserved word, and every SC, ends the reservation
  assign resv_set_o   = (state_q == ST_MODIFY) && (op_q == MEM_AMO_LR);
  assign resv_clear_o = (state_q == ST_MODIFY) &&
                        ((op_q == MEM_AMO_SC) || (wr_en_o && resv_hit_i));
  assign resv_addr_o  = addr_q;

  assign mem.rsp_valid = (state_q == ST_RESP);
  assign mem.rsp_rdata = (op_q == MEM_AMO_SC) ? {63'b0, sc_fail_q} : rdata_i;
  assign mem.rsp_tid   = tid_q;

  // Response latency counted from the accepting edge
  load_rsp_a : assert property (@(posedge clk_i) disable iff (reset_i)
    accept && (mem.req_op == MEM_LOAD) && mem.req_need_rsp |-> ##2 mem.rsp_valid)
    else $error("load response missing two cycles after acceptance");

  amo_rsp_a : assert property (@(posedge clk_i) disable iff (reset_i)
    accept && !(mem.req_op inside {MEM_LOAD, MEM_STORE}) && mem.req_need_rsp
    |-> ##3 mem.rsp_valid)
    else $error("AMO response missing three cycles after acceptance");

endmodule

//--- src/lr_reservation_timer.sv
`timescale 1ns/1ps
`include "amo_port_consts.svh"

module lr_reservation_timer (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   set_i,
  input  logic                   clear_i,
  input  logic [`AMO_ADDR_W-4:0] addr_i,
  input  logic [`AMO_ADDR_W-4:0] check_addr_i,
  output logic                   valid_o,
  output logic                   hit_o
);
  localparam int CNT_W = $clog2(`AMO_LR_TIMEOUT + 1);

  logic [CNT_W-1:0]       count_q;
  logic                   valid_q;
  logic [`AMO_ADDR_W-4:0] addr_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      count_q <= '0;
    end else if (set_i) begin
      valid_q <= 1'b1;
      count_q <= CNT_W'(`AMO_LR_TIMEOUT);
    end else if (clear_i) begin
      valid_q <= 1'b0;
      count_q <= '0;
    end else if (valid_q) begin
      count_q <= count_q - 1'b1;
      // Expires as the count reaches zero
      if (count_q == CNT_W'(1)) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (set_i) begin
      addr_q <= addr_i;
    end
  end

  assign valid_o = valid_q;
  assign hit_o   = valid_q && (check_addr_i == addr_q);

endmodule

//--- src/amo_data_unit.sv
`timescale 1ns/1ps
`include "amo_port_consts.svh"

module amo_data_unit (
  input  logic                      clk_i,
  input  logic                      rd_en_i,
  input  logic                      wr_en_i,
  input  logic [`AMO_ADDR_W-4:0]    word_addr_i,
  input  logic [63:0]               wdata_i,
  input  logic [7:0]                be_i,
  input  mem_req_pkg::mem_op_e      op_i,
  input  core_if_pkg::access_size_e size_i,
  output logic [63:0]               rdata_o,
  output logic [63:0]               alu_result_o
);
  import core_if_pkg::*;
  import mem_req_pkg::*;

  logic [63:0] mem_q [`AMO_MEM_WORDS];
  logic [63:0] rdata_q;
  logic [63:0] operand_q;
  logic        is_word;
  logic        hi_half;
  logic [31:0] a_half;
  logic [31:0] b_half;
  logic [63:0] a_s;
  logic [63:0] b_s;
  logic [63:0] a_u;
  logic [63:0] b_u;
  logic [63:0] res;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int i = 0; i < 8; i++) begin
        if (be_i[i]) begin
          mem_q[word_addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
    // Old value and operand latched together for the ALU
    if (rd_en_i) begin
      rdata_q   <= mem_q[word_addr_i];
      operand_q <= wdata_i;
    end
  end

  assign is_word = (size_i == SIZE_WORD);
  assign hi_half = be_i[4];

  always_comb begin
    a_half = hi_half ? rdata_q[63:32] : rdata_q[31:0];
    b_half = hi_half ? operand_q[63:32] : operand_q[31:0];
    // Signed and unsigned views, word operands widened
    a_s = is_word ? {{32{a_half[31]}}, a_half} : rdata_q;
    b_s = is_word ? {{32{b_half[31]}}, b_half} : operand_q;
    a_u = is_word ? {32'b0, a_half} : rdata_q;
    b_u = is_word ? {32'b0, b_half} : operand_q;
    unique case (op_i)
      MEM_AMO_SWAP, MEM_AMO_SC: res = b_s;
      MEM_AMO_ADD:  res = a_s + b_s;
      MEM_AMO_AND:  res = a_s & b_s;
      MEM_AMO_OR:   res = a_s | b_s;
      MEM_AMO_XOR:  res = a_s ^ b_s;
      MEM_AMO_MAX:  res = ($signed(a_s) > $signed(b_s)) ? a_s : b_s;
      MEM_AMO_MAXU: res = (a_u > b_u) ? a_s : b_s;
      MEM_AMO_MIN:  res = ($signed(a_s) < $signed(b_s)) ? a_s : b_s;
      MEM_AMO_MINU: res = (a_u < b_u) ? a_s : b_s;
      default:      res = a_s;
    endcase
  end

  // Word result copied to both halves, byte enables keep the other one
  assign alu_result_o = is_word ? {2{res[31:0]}} : res;
  assign rdata_o      = rdata_q;

endmodule

//--- src/amo_subsys_top.sv
`timescale 1ns/1ps
`include "amo_port_consts.svh"

module amo_subsys_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      data_req_i,
  input  logic                      data_we_i,
  input  logic [`AMO_ADDR_W-1:0]    data_addr_i,
  input  logic [63:0]               data_wdata_i,
  input  logic [7:0]                data_be_i,
  input  core_if_pkg::access_size_e data_size_i,
  input  mem_req_pkg::mem_tid_t     data_id_i,
  output logic                      data_gnt_o,
  output logic                      data_rvalid_o,
  output logic [63:0]               data_rdata_o,
  output mem_req_pkg::mem_tid_t     data_rid_o,
  input  logic                      amo_req_i,
  input  core_if_pkg::amo_op_e      amo_op_i,
  input  logic [`AMO_ADDR_W-1:0]    amo_addr_i,
  input  logic [63:0]               amo_operand_i,
  input  core_if_pkg::access_size_e amo_size_i,
  output logic                      amo_ack_o,
  output logic [63:0]               amo_result_o
);
  import mem_req_pkg::*;

  localparam int WORD_AW = `AMO_ADDR_W - 3;

  mem_req_if mem_bus ();

  logic               rd_en;
  logic               wr_en;
  logic [WORD_AW-1:0] word_addr;
  logic [63:0]        wdata;
  logic [7:0]         be;
  mem_op_e            op;
  logic [63:0]        rdata;
  logic [63:0]        alu_result;
  logic               resv_set;
  logic               resv_clear;
  logic [WORD_AW-1:0] resv_addr;
  logic               resv_valid;
  logic               resv_hit;

  core_port_adapter u_adapter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_be_i     (data_be_i),
    .data_size_i   (data_size_i),
    .data_id_i     (data_id_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .data_rid_o    (data_rid_o),
    .amo_req_i     (amo_req_i),
    .amo_op_i      (amo_op_i),
    .amo_addr_i    (amo_addr_i),
    .amo_operand_i (amo_operand_i),
    .amo_size_i    (amo_size_i),
    .amo_ack_o     (amo_ack_o),
    .amo_result_o  (amo_result_o),
    .mem           (mem_bus.requester)
  );

  scratch_ctrl_fsm u_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem          (mem_bus.responder),
    .rd_en_o      (rd_en),
    .wr_en_o      (wr_en),
    .word_addr_o  (word_addr),
    .wdata_o      (wdata),
    .be_o         (be),
    .op_o         (op),
    .rdata_i      (rdata),
    .alu_result_i (alu_result),
    .resv_set_o   (resv_set),
    .resv_clear_o (resv_clear),
    .resv_addr_o  (resv_addr),
    .resv_valid_i (resv_valid),
    .resv_hit_i   (resv_hit)
  );

  lr_reservation_timer u_resv (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .set_i        (resv_set),
    .clear_i      (resv_clear),
    .addr_i       (resv_addr),
    .check_addr_i (resv_addr),
    .valid_o      (resv_valid),
    .hit_o        (resv_hit)
  );

  // AMO size stays on the bus until the ack, so the ALU reads it live
  amo_data_unit u_data (
    .clk_i        (clk_i),
    .rd_en_i      (rd_en),
    .wr_en_i      (wr_en),
    .word_addr_i  (word_addr),
    .wdata_i      (wdata),
    .be_i         (be),
    .op_i         (op),
    .size_i       (mem_bus.req_size),
    .rdata_o      (rdata),
    .alu_result_o (alu_result)
  );

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset drops on a rising edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

//--- bench/amo_subsys_tb.sv
`timescale 1ns/1ps
`include "amo_port_consts.svh"

module amo_subsys_tb;
  import core_if_pkg::*;
  import mem_req_pkg::*;

  localparam int HS_TIMEOUT = 16;
  localparam int OP_CYCLES  = 12;
  localparam int SEL_GNT    = 0;
  localparam int SEL_RVALID = 1;
  localparam int SEL_ACK    = 2;
  // Fill, then tests 2 to 6 in request count, plus the LR expiry wait
  localparam int NUM_OPS    = `AMO_MEM_WORDS + 32 + 32 + 18 + 6 + 12;
  localparam int WATCHDOG_CYCLES = 2 * (NUM_OPS * OP_CYCLES + 2 * `AMO_LR_TIMEOUT + 32);

  logic                   clk_i;
  logic                   reset_i;
  logic                   data_req_i;
  logic                   data_we_i;
  logic [`AMO_ADDR_W-1:0] data_addr_i;
  logic [63:0]            data_wdata_i;
  logic [7:0]             data_be_i;
  access_size_e           data_size_i;
  mem_tid_t               data_id_i;
  logic                   data_gnt_o;
  logic                   data_rvalid_o;
  logic [63:0]            data_rdata_o;
  mem_tid_t               data_rid_o;
  logic                   amo_req_i;
  amo_op_e                amo_op_i;
  logic [`AMO_ADDR_W-1:0] amo_addr_i;
  logic [63:0]            amo_operand_i;
  access_size_e           amo_size_i;
  logic                   amo_ack_o;
  logic [63:0]            amo_result_o;

  // Reference model state
  logic [63:0] ref_mem [`AMO_MEM_WORDS];
  logic [63:0] exp_rdata;
  logic [63:0] exp_amo;
  mem_tid_t    exp_rid;
  logic        resv_valid;
  int          resv_word;
  int          resv_cycle;
  int          cycle_cnt;
  int          seed;
  int          err_count;
  int          test_count;
  int          loads_done;
  int          amos_done;
  logic [1:0]  gnt_hist;
  wire         load_gnt = data_req_i & data_gnt_o & ~data_we_i;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clk_gen (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  amo_subsys_top amo_subsys_top_i (.*);

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (reset_i) begin
      gnt_hist <= '0;
    end else begin
      gnt_hist <= {gnt_hist[0], load_gnt};
    end
  end

  gnt_a : assert property (@(posedge clk_i) disable iff (reset_i) data_req_i |-> data_gnt_o)
    else begin
      $display("FAILED data_gnt_o got %h expected 1", $sampled(data_gnt_o));
      err_count++;
    end

  // Load data comes back two cycles after its grant, never otherwise
  rvalid_a : assert property (@(posedge clk_i) disable iff (reset_i)
    data_rvalid_o == gnt_hist[1])
    else begin
      $display("FAILED data_rvalid_o got %h expected %h", $sampled(data_rvalid_o),
               $sampled(gnt_hist[1]));
      err_count++;
    end

  rdata_a : assert property (@(posedge clk_i) disable iff (reset_i)
    data_rvalid_o |-> data_rdata_o == exp_rdata)
    else begin
      $display("FAILED data_rdata_o got %h expected %h", $sampled(data_rdata_o),
               $sampled(exp_rdata));
      err_count++;
    end

  rid_a : assert property (@(posedge clk_i) disable iff (reset_i)
    data_rvalid_o |-> data_rid_o == exp_rid)
    else begin
      $display("FAILED data_rid_o got %h expected %h", $sampled(data_rid_o), $sampled(exp_rid));
      err_count++;
    end

  ack_a : assert property (@(posedge clk_i) disable iff (reset_i) amo_ack_o |-> amo_req_i)
    else begin
      $display("AMO ack seen with no AMO request pending");
      err_count++;
    end

  amo_result_a : assert property (@(posedge clk_i) disable iff (reset_i)
    amo_ack_o |-> amo_result_o == exp_amo)
    else begin
      $display("FAILED amo_result_o got %h expected %h", $sampled(amo_result_o),
               $sampled(exp_amo));
      err_count++;
    end

  function automatic logic [`AMO_ADDR_W-1:0] byte_addr(input int word, input logic hi);
    return {word[`AMO_ADDR_W-4:0], hi, 2'b00};
  endfunction

  function automatic mem_tid_t random_tid();
    mem_tid_t t;
    t = mem_tid_t'($random(seed));
    // All-ones belongs to the AMO channel
    if (t == AMO_TID) begin
      t = 4'h0;
    end
    return t;
  endfunction

  function automatic logic [63:0] alu_model(input amo_op_e op, input logic [63:0] a,
                                            input logic [63:0] b);
    case (op)
      AMO_ADD:  return a + b;
      AMO_AND:  return a & b;
      AMO_OR:   return a | b;
      AMO_XOR:  return a ^ b;
      AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
      AMO_MAXU: return (a > b) ? a : b;
      AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      AMO_MINU: return (a < b) ? a : b;
      default:  return b;
    endcase
  endfunction

  // Polls at falling edges, then steps onto the accepting rising edge
  task automatic await_strobe(input int sel, input string what);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < HS_TIMEOUT) begin
      @(negedge clk_i);
      case (sel)
        SEL_GNT:    seen = data_gnt_o;
        SEL_RVALID: seen = data_rvalid_o;
        default:    seen = amo_ack_o;
      endcase
      n++;
    end
    if (!seen) begin
      $display("timed out after %0d cycles waiting for %s", HS_TIMEOUT, what);
      err_count++;
    end
    @(posedge clk_i);
  endtask

  task automatic store_word(input int word, input logic [63:0] wdata, input logic [7:0] be);
    @(posedge clk_i);
    data_req_i   <= 1'b1;
    data_we_i    <= 1'b1;
    data_addr_i  <= byte_addr(word, 1'b0);
    data_wdata_i <= wdata;
    data_be_i    <= be;
    data_size_i  <= SIZE_DOUBLE;
    data_id_i    <= random_tid();
    await_strobe(SEL_GNT, "data_gnt_o on a store");
    data_req_i <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) begin
        ref_mem[word][8*i +: 8] = wdata[8*i +: 8];
      end
    end
    if (resv_word == word) begin
      resv_valid = 1'b0;
    end
  endtask

  task automatic load_word(input int word);
    mem_tid_t tid;
    @(posedge clk_i);
    tid = random_tid();
    exp_rdata = ref_mem[word];
    exp_rid = tid;
    data_req_i  <= 1'b1;
    data_we_i   <= 1'b0;
    data_addr_i <= byte_addr(word, 1'b0);
    data_be_i   <= 8'hFF;
    data_size_i <= SIZE_DOUBLE;
    data_id_i   <= tid;
    await_strobe(SEL_GNT, "data_gnt_o on a load");
    data_req_i <= 1'b0;
    await_strobe(SEL_RVALID, "data_rvalid_o");
    loads_done++;
  endtask

  task automatic run_amo(input amo_op_e op, input int word, input logic hi,
                         input logic [63:0] operand, input access_size_e size);
    logic [63:0] old;
    logic [63:0] res;
    logic [31:0] old_half;
    logic        sc_ok;
    @(posedge clk_i);
    old = ref_mem[word];
    old_half = hi ? old[63:32] : old[31:0];
    sc_ok = resv_valid && (resv_word == word) && (cycle_cnt - resv_cycle < `AMO_LR_TIMEOUT);
    if (op == AMO_SC) begin
      exp_amo = {63'b0, ~sc_ok};
    end else if (size == SIZE_WORD) begin
      exp_amo = {{32{old_half[31]}}, old_half};
    end else begin
      exp_amo = old;
    end
    amo_req_i     <= 1'b1;
    amo_op_i      <= op;
    amo_addr_i    <= byte_addr(word, hi);
    amo_operand_i <= operand;
    amo_size_i    <= size;
    await_strobe(SEL_ACK, "amo_ack_o");
    amo_req_i <= 1'b0;
    amos_done++;
    if (op == AMO_LR) begin
      resv_valid = 1'b1;
      resv_word  = word;
      resv_cycle = cycle_cnt;
    end else begin
      if (op != AMO_SC || sc_ok) begin
        if (size == SIZE_WORD) begin
          res = alu_model(op, {{32{old_half[31]}}, old_half},
                          {{32{operand[31]}}, operand[31:0]});
          ref_mem[word] = hi ? {res[31:0], old[31:0]} : {old[63:32], res[31:0]};
        end else begin
          ref_mem[word] = alu_model(op, old, operand);
        end
      end
      if (op == AMO_SC || resv_word == word) begin
        resv_valid = 1'b0;
      end
    end
  endtask

  // Action blocks of the last edge have run by the falling edge
  task automatic report_test(input string name, input int errs_before);
    @(negedge clk_i);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
    end
  endtask

  initial begin
    amo_op_e     op;
    int          words [16];
    int          errs;
    int          w;
    logic [63:0] val;
    seed = 32'h4de;
    err_count = 0;
    test_count = 0;
    loads_done = 0;
    amos_done = 0;
    cycle_cnt = 0;
    resv_valid = 1'b0;
    resv_word = -1;
    resv_cycle = 0;
    exp_rdata = '0;
    exp_amo = '0;
    exp_rid = '0;
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    data_addr_i = '0;
    data_wdata_i = '0;
    data_be_i = '0;
    data_size_i = SIZE_DOUBLE;
    data_id_i = '0;
    amo_req_i = 1'b0;
    amo_op_i = AMO_LR;
    amo_addr_i = '0;
    amo_operand_i = '0;
    amo_size_i = SIZE_DOUBLE;
    while (reset_i !== 1'b0) @(posedge clk_i);

    // Quiet outputs, then a full fill through the data channel
    errs = err_count;
    repeat (8) @(posedge clk_i);
    for (int i = 0; i < `AMO_MEM_WORDS; i++) begin
      store_word(i, {32'(i) * 32'h9e37_79b9, ~32'(i)}, 8'hFF);
    end
    report_test("reset and fill", errs);

    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      words[i] = $random(seed) & (`AMO_MEM_WORDS - 1);
      store_word(words[i], {$random(seed), $random(seed)}, 8'hFF);
    end
    for (int i = 0; i < 16; i++) begin
      load_word(words[i]);
    end
    report_test("store then load", errs);

    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      w = $random(seed) & (`AMO_MEM_WORDS - 1);
      store_word(w, {$random(seed), $random(seed)}, 8'($random(seed)));
      load_word(w);
    end
    report_test("partial stores", errs);

    errs = err_count;
    op = AMO_SWAP;
    repeat (9) begin
      w = $random(seed) & (`AMO_MEM_WORDS - 1);
      run_amo(op, w, 1'b0, {$random(seed), $random(seed)}, SIZE_DOUBLE);
      load_word(w);
      op = op.next();
    end
    report_test("double AMOs", errs);

    errs = err_count;
    for (int h = 0; h < 2; h++) begin
      w = $random(seed) & (`AMO_MEM_WORDS - 1);
      run_amo(AMO_ADD, w, h[0], {$random(seed), $random(seed)}, SIZE_WORD);
      run_amo(AMO_MIN, w, h[0], {$random(seed), $random(seed)}, SIZE_WORD);
      load_word(w);
    end
    report_test("word AMOs", errs);

    // LR/SC pass, then broken by a store, by expiry and by a wrong address
    errs = err_count;
    w = 12;
    val = {$random(seed), $random(seed)};
    run_amo(AMO_LR, w, 1'b0, '0, SIZE_DOUBLE);
    run_amo(AMO_SC, w, 1'b0, val, SIZE_DOUBLE);
    load_word(w);
    run_amo(AMO_LR, w, 1'b0, '0, SIZE_DOUBLE);
    store_word(w, {$random(seed), $random(seed)}, 8'hFF);
    run_amo(AMO_SC, w, 1'b0, val + 1, SIZE_DOUBLE);
    load_word(w);
    run_amo(AMO_LR, w, 1'b0, '0, SIZE_DOUBLE);
    repeat (`AMO_LR_TIMEOUT + 16) @(posedge clk_i);
    run_amo(AMO_SC, w, 1'b0, val + 2, SIZE_DOUBLE);
    run_amo(AMO_LR, w, 1'b0, '0, SIZE_DOUBLE);
    run_amo(AMO_SC, w + 1, 1'b0, val + 3, SIZE_DOUBLE);
    load_word(w + 1);
    report_test("LR and SC", errs);

    $display("%0d tests, %0d loads, %0d atomics, %0d errors",
             test_count, loads_done, amos_done, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- amo_subsys.f
+incdir+include
src/core_if_pkg.sv
src/mem_req_pkg.sv
src/mem_req_if.sv
src/core_port_adapter.sv
src/scratch_ctrl_fsm.sv
src/lr_reservation_timer.sv
src/amo_data_unit.sv
src/amo_subsys_top.sv
bench/tb_clock_gen.sv
bench/amo_subsys_tb.sv

//--- Makefile
# Verilator simulation of the AMO port subsystem

VERILATOR ?= verilator
TOP       ?= amo_subsys_tb
FILELIST  ?= amo_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
